// ==== list.f ====
+incdir+verilog
verilog/enc_pkg.sv
verilog/enc_quad_decode.sv
verilog/enc_period_meas.sv
verilog/enc_position_counter.sv
verilog/enc_channel.sv
verification/tb_clock_gen.sv
verification/enc_checker.sv
verification/enc_tb_top.sv

// ==== Bender.yml ====
package:
  name: enc_channel

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/enc_pkg.sv
      - verilog/enc_quad_decode.sv
      - verilog/enc_period_meas.sv
      - verilog/enc_position_counter.sv
      - verilog/enc_channel.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/enc_checker.sv
      - verification/enc_tb_top.sv

// ==== verification/enc_tb_top.sv ====
`timescale 1ns/1ps
// testbench top for the quadrature encoder channel
// plans gray steps with lfsr gaps and directions, drives a and b on the
// falling edge and prints one line per test plus a summary
// the checker module holds the model and does the comparing

`include "enc_cfg.svh"

module enc_tb_top
    import enc_pkg::*;
();

    // planned move along the gray sequence
    localparam int kind_fwd  = 0;
    localparam int kind_back = 1;
    localparam int kind_bad  = 2;

    logic                             clk_fast;
    logic                             reset;
    logic                             a;
    logic                             b;
    enc_meas_t                        meas;
    logic                             meas_valid;
    logic signed [`ENC_POS_WIDTH-1:0] position;
    logic                             illegal;
    int                               error_count;
    int                               pending;

    logic [31:0] lfsr_state;
    int          plan_gap[$];
    int          plan_kind[$];
    int          plan_pos;
    // index into 00 01 11 10
    int          gray_pos;
    int          cycle_count;
    int          cycle_limit;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen u_tb_clock_gen (
        .clk_fast (clk_fast),
        .reset    (reset)
    );

    enc_channel u_enc_channel (
        .clk_fast   (clk_fast),
        .reset      (reset),
        .a          (a),
        .b          (b),
        .meas       (meas),
        .meas_valid (meas_valid),
        .position   (position),
        .illegal    (illegal)
    );

    enc_checker u_enc_checker (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .a           (a),
        .b           (b),
        .meas        (meas),
        .meas_valid  (meas_valid),
        .position    (position),
        .illegal     (illegal),
        .error_count (error_count),
        .pending     (pending)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // one lfsr step per bit
    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    // 2 to 300 cycles
    function automatic int random_gap();
        return 2 + take_bits(9) % 299;
    endfunction

    function automatic logic [1:0] gray_code(input int idx);
        case (idx)
            0:       return 2'b00;
            1:       return 2'b01;
            2:       return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    // mode 0 forward, 1 backward, 2 random direction, 3 mixed with illegal
    task automatic plan_steps(input int count, input int mode);
        int kind;
        int pick;
        for (int i = 0; i < count; i++)
        begin
            case (mode)
                0:       kind = kind_fwd;
                1:       kind = kind_back;
                2:       kind = take_bits(1) ? kind_fwd : kind_back;
                default:
                begin
                    pick = take_bits(2);
                    kind = (pick == 0) ? kind_bad : ((pick == 1) ? kind_back : kind_fwd);
                end
            endcase
            plan_kind.push_back(kind);
            plan_gap.push_back(random_gap());
        end
    endtask

    task automatic plan_one(input int kind, input int gap);
        plan_kind.push_back(kind);
        plan_gap.push_back(gap);
    endtask

    // drive the next planned changes, then wait for the checker to drain
    task automatic run_test(input string name, input int count);
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < count; i++)
        begin
            repeat (plan_gap[plan_pos]) @(negedge clk_fast);
            case (plan_kind[plan_pos])
                kind_fwd:  gray_pos = (gray_pos + 1) % 4;
                kind_back: gray_pos = (gray_pos + 3) % 4;
                default:   gray_pos = (gray_pos + 2) % 4;
            endcase
            {a, b} = gray_code(gray_pos);
            plan_pos++;
        end
        repeat (2) @(negedge clk_fast);
        while (pending != 0)
        begin
            @(negedge clk_fast);
        end
        // room for any stray output
        repeat (4) @(negedge clk_fast);
        tests_run++;
        if (error_count == errors_before)
        begin
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // run limit from the planned gaps
    always @(posedge clk_fast)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        a            = 1'b0;
        b            = 1'b0;
        lfsr_state   = 32'he081d709;
        plan_pos     = 0;
        gray_pos     = 0;
        cycle_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        plan_steps(20, 0);
        plan_steps(20, 1);
        plan_steps(24, 2);
        // slow gap, then both sides of the saturation limit
        plan_one(kind_fwd, `ENC_PERIOD_MAX + take_bits(8));
        plan_one(kind_fwd, `ENC_PERIOD_MAX - 1);
        plan_one(kind_fwd, `ENC_PERIOD_MAX);
        plan_steps(16, 3);
        cycle_limit = 1000;
        foreach (plan_gap[i])
        begin
            cycle_limit += plan_gap[i];
        end
        wait (reset === 1'b0);
        run_test("reset state", 0);
        run_test("forward", 20);
        run_test("backward", 20);
        run_test("reversal", 24);
        run_test("overflow", 3);
        run_test("illegal", 16);
        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verification/enc_checker.sv ====
`timescale 1ns/1ps
// checker for the encoder channel testbench
// watches a and b, predicts one result per input change and compares
// meas, meas_valid, illegal and position against that prediction
// the decode delay is fixed so input gaps equal the measured gaps

`include "enc_cfg.svh"

module enc_checker
    import enc_pkg::*;
(
    input  logic                             clk_fast,
    input  logic                             reset,
    input  logic                             a,
    input  logic                             b,
    input  enc_meas_t                        meas,
    input  logic                             meas_valid,
    input  logic signed [`ENC_POS_WIDTH-1:0] position,
    input  logic                             illegal,
    output int                               error_count,
    output int                               pending
);

    // predicted outcome of one input change
    typedef struct packed {
        logic      is_illegal;
        enc_meas_t meas;
    } expect_t;

    expect_t                          expect_q[$];
    // cycles since reset, sampled on the rising edge
    int                               cycle_idx;
    int                               last_step_cycle;
    logic                             first_step;
    logic                             last_dir;
    logic [1:0]                       code_prev;
    // count after the newest predicted step
    logic signed [`ENC_POS_WIDTH-1:0] model_pos;
    // count the DUT should be showing right now
    logic signed [`ENC_POS_WIDTH-1:0] pos_shown;
    // first cycle out of reset
    logic                             fresh;

    initial
    begin
        error_count = 0;
        pending     = 0;
    end

    // position in the forward order 00 01 11 10
    function automatic int gray_index(input logic [1:0] code);
        case (code)
            2'b00:   return 0;
            2'b01:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("FAILED %s: got %h, expected %h at cycle %0d",
                     name, got, expected, cycle_idx);
            error_count++;
        end
    endtask

    task automatic report_problem(input string text);
        $display("error at cycle %0d: %s", cycle_idx, text);
        error_count++;
    endtask

    // apply the measurement rule to a new code on a and b
    task automatic model_change(input logic [1:0] code_now);
        int      diff;
        int      step_gap;
        expect_t entry;
        diff  = (gray_index(code_now) - gray_index(code_prev)) & 3;
        entry = '0;
        if (diff == 2)
        begin
            // both lines flipped
            entry.is_illegal = 1'b1;
        end
        else
        begin
            entry.meas.dir      = (diff == 1);
            step_gap            = cycle_idx - last_step_cycle;
            model_pos           = model_pos + (entry.meas.dir ? 1 : -1);
            entry.meas.position = model_pos;
            if (first_step || step_gap >= `ENC_PERIOD_MAX)
            begin
                entry.meas.overflow = 1'b1;
            end
            else if (entry.meas.dir != last_dir)
            begin
                entry.meas.reversal = 1'b1;
            end
            else
            begin
                entry.meas.period = entry.meas.dir ? step_gap : -step_gap;
            end
            first_step      = 1'b0;
            last_dir        = entry.meas.dir;
            last_step_cycle = cycle_idx;
        end
        expect_q.push_back(entry);
    endtask

    task automatic compare_meas();
        expect_t entry;
        if (expect_q.size() == 0)
        begin
            report_problem("meas_valid without any change on a and b");
        end
        else
        begin
            entry = expect_q.pop_front();
            if (entry.is_illegal)
            begin
                report_problem("meas_valid where an illegal transition was due");
            end
            else
            begin
                check_value("meas.period", $unsigned(meas.period),
                            $unsigned(entry.meas.period));
                check_value("meas.position", $unsigned(meas.position),
                            $unsigned(entry.meas.position));
                check_value("meas.dir", meas.dir, entry.meas.dir);
                check_value("meas.overflow", meas.overflow, entry.meas.overflow);
                check_value("meas.reversal", meas.reversal, entry.meas.reversal);
                pos_shown = entry.meas.position;
            end
        end
    endtask

    task automatic compare_illegal();
        expect_t entry;
        if (expect_q.size() == 0)
        begin
            report_problem("illegal without any change on a and b");
        end
        else
        begin
            entry = expect_q.pop_front();
            if (!entry.is_illegal)
            begin
                report_problem("illegal pulsed for a legal gray step");
            end
        end
    endtask

    // everything quiet and zero right after reset
    task automatic check_reset_state();
        check_value("meas_valid", meas_valid, 1'b0);
        check_value("illegal", illegal, 1'b0);
        check_value("position", $unsigned(position), 32'h0);
        check_value("meas.period", $unsigned(meas.period), 32'h0);
        check_value("meas.position", $unsigned(meas.position), 32'h0);
        check_value("meas flags", {meas.dir, meas.overflow, meas.reversal}, 32'h0);
    endtask

    // inputs settle on the falling edge, outputs read before they update
    always @(posedge clk_fast)
    begin
        if (reset)
        begin
            expect_q.delete();
            cycle_idx       = 0;
            last_step_cycle = 0;
            first_step      = 1'b1;
            last_dir        = 1'b0;
            code_prev       = 2'b00;
            model_pos       = '0;
            pos_shown       = '0;
            fresh           = 1'b1;
            pending         = 0;
        end
        else
        begin
            cycle_idx++;
            if (fresh)
            begin
                check_reset_state();
                fresh = 1'b0;
            end
            if ({a, b} != code_prev)
            begin
                model_change({a, b});
                code_prev = {a, b};
            end
            if (meas_valid && illegal)
            begin
                report_problem("meas_valid and illegal high in the same cycle");
            end
            else if (meas_valid)
            begin
                compare_meas();
            end
            else if (illegal)
            begin
                compare_illegal();
            end
            // position only moves with meas_valid
            check_value("position", $unsigned(position), $unsigned(pos_shown));
            pending = expect_q.size();
        end
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
// clock and reset source for the encoder testbench
// clk_fast runs at a 100 ns period from time zero
// reset is high for the first 4 cycles and drops on a falling edge

module tb_clock_gen
(
    output logic clk_fast,
    output logic reset
);

    // 50 ns half period
    initial
    begin
        clk_fast = 1'b0;
        forever #50 clk_fast = ~clk_fast;
    end

    // release away from the rising edge
    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge clk_fast);
        @(negedge clk_fast);
        reset = 1'b0;
    end

endmodule

// ==== verilog/enc_channel.sv ====
`timescale 1ns/1ps
// one quadrature encoder channel
// decodes a and b, tracks position and measures the step period
// meas is published with a one cycle meas_valid per step and holds until the next
// illegal pulses in the slot meas_valid would have used

`include "enc_cfg.svh"

module enc_channel
    import enc_pkg::*;
(
    input  logic                             clk_fast,
    input  logic                             reset,
    input  logic                             a,
    input  logic                             b,
    output enc_meas_t                        meas,
    output logic                             meas_valid,
    output logic signed [`ENC_POS_WIDTH-1:0] position,
    output logic                             illegal
);

    // decoded steps to both consumers
    enc_step_t                           step_info;
    // period meter results
    logic signed [`ENC_PERIOD_WIDTH-1:0] period;
    logic                                overflow;
    logic                                reversal;
    logic                                meas_strobe;
    // direction of the last legal step
    logic                                dir_q;
    // illegal delayed into the meas_valid slot
    logic                                illegal_q;

    enc_quad_decode u_enc_quad_decode (
        .clk_fast  (clk_fast),
        .reset     (reset),
        .a         (a),
        .b         (b),
        .step_info (step_info)
    );

    enc_period_meas u_enc_period_meas (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .step_info   (step_info),
        .period      (period),
        .overflow    (overflow),
        .reversal    (reversal),
        .meas_strobe (meas_strobe)
    );

    enc_position_counter u_enc_position_counter (
        .clk_fast  (clk_fast),
        .reset     (reset),
        .step_info (step_info),
        .position  (position)
    );

    // direction and illegal aligned with the period meter output
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            dir_q     <= 1'b0;
            illegal_q <= 1'b0;
        end
        else
        begin
            illegal_q <= step_info.illegal;
            if (step_info.step)
            begin
                dir_q <= step_info.dir;
            end
        end
    end

    // measurement word
    // all fields change only on the edge that raises meas_valid
    always_comb
    begin
        meas.period   = period;
        meas.position = position;
        meas.dir      = dir_q;
        meas.overflow = overflow;
        meas.reversal = reversal;
    end

    assign meas_valid = meas_strobe;
    assign illegal    = illegal_q;

endmodule

// ==== verilog/enc_position_counter.sv ====
`timescale 1ns/1ps
// position counter for the quadrature encoder channel
// up on forward steps, down on backward steps, wraps at either end
// output is registered so it moves together with meas_valid

`include "enc_cfg.svh"

module enc_position_counter
    import enc_pkg::*;
(
    input  logic                             clk_fast,
    input  logic                             reset,
    input  enc_step_t                        step_info,
    output logic signed [`ENC_POS_WIDTH-1:0] position
);

    localparam int pos_w = `ENC_POS_WIDTH;

    // plus or minus one for this step
    logic signed [pos_w-1:0] delta;

    assign delta = step_info.dir ? pos_w'(1) : -pos_w'(1);

    // running count with plain two's complement wrap
    // illegal transitions never raise step so they leave the count alone
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            position <= '0;
        end
        else if (step_info.step)
        begin
            position <= position + delta;
        end
    end

endmodule

// ==== verilog/enc_period_meas.sv ====
`timescale 1ns/1ps
// period meter for the quadrature encoder channel
// counts clk_fast cycles between decoded steps and latches a signed period
// result registers and meas_strobe come one cycle after the step pulse
// period is zero with a flag set on overflow or direction reversal

`include "enc_cfg.svh"

module enc_period_meas
    import enc_pkg::*;
(
    input  logic                                clk_fast,
    input  logic                                reset,
    input  enc_step_t                           step_info,
    output logic signed [`ENC_PERIOD_WIDTH-1:0] period,
    output logic                                overflow,
    output logic                                reversal,
    output logic                                meas_strobe
);

    localparam int period_w = `ENC_PERIOD_WIDTH;
    // parking value of the elapsed counter
    localparam logic [period_w-1:0] cnt_max = `ENC_PERIOD_MAX;

    // cycles since the last step, unsigned
    // reads N in the cycle of the next step
    logic [period_w-1:0]        elapsed;
    // same count seen as a signed magnitude
    // below cnt_max the top bit is clear
    logic signed [period_w-1:0] elapsed_s;
    // direction of the previous step
    logic                       dir_prev;

    assign elapsed_s = $signed(elapsed);

    // elapsed counter and reversal reference
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            // start saturated so the first step reads as overflow
            elapsed  <= cnt_max;
            dir_prev <= 1'b0;
        end
        else if (step_info.step)
        begin
            // step cycle counts as cycle 1 of the next gap
            elapsed  <= {{(period_w-1){1'b0}}, 1'b1};
            dir_prev <= step_info.dir;
        end
        else if (elapsed != cnt_max)
        begin
            elapsed <= elapsed + 1'b1;
        end
    end

    // latch the measurement on each step
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            period      <= '0;
            overflow    <= 1'b0;
            reversal    <= 1'b0;
            meas_strobe <= 1'b0;
        end
        else
        begin
            meas_strobe <= step_info.step;
            if (step_info.step)
            begin
                if (elapsed >= cnt_max)
                begin
                    // too slow to measure
                    period   <= '0;
                    overflow <= 1'b1;
                    reversal <= 1'b0;
                end
                else if (step_info.dir != dir_prev)
                begin
                    // gap spans a turnaround, no meaningful period
                    period   <= '0;
                    overflow <= 1'b0;
                    reversal <= 1'b1;
                end
                else
                begin
                    // sign follows direction
                    period   <= step_info.dir ? elapsed_s : -elapsed_s;
                    overflow <= 1'b0;
                    reversal <= 1'b0;
                end
            end
        end
    end

    // counter parks at the limit and never passes it
    a_elapsed_bound: assert property (
        @(posedge clk_fast) disable iff (reset)
        elapsed <= cnt_max
    );

    // steps arrive at least two cycles apart
    a_strobe_single: assert property (
        @(posedge clk_fast) disable iff (reset)
        meas_strobe |=> !meas_strobe
    );

endmodule

// ==== verilog/enc_quad_decode.sv ====
`timescale 1ns/1ps
// quadrature decoder for one encoder channel
// brings the asynchronous a and b lines into clk_fast and turns each
// legal gray transition into a single cycle step with a direction
// a change sampled at edge k shows on step_info after edge k+2

module enc_quad_decode
    import enc_pkg::*;
(
    input  logic      clk_fast,
    input  logic      reset,
    input  logic      a,
    input  logic      b,
    output enc_step_t step_info
);

    // synchronizer stages, code is {a, b}
    logic [1:0] sync_1;
    logic [1:0] sync_2;
    // code seen on the previous cycle
    logic [1:0] code_prev;
    // fills with ones after reset
    // compare only once sync_2 and code_prev hold real samples
    logic [2:0] warm;
    // bits that moved since last cycle
    logic [1:0] code_diff;
    enc_step_t  step_next;

    // two flop synchronizer on both lines
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            sync_1 <= 2'b00;
            sync_2 <= 2'b00;
        end
        else
        begin
            sync_1 <= {a, b};
            sync_2 <= sync_1;
        end
    end

    assign code_diff = sync_2 ^ code_prev;

    // classify the transition
    // forward order is 00 01 11 10
    always_comb
    begin
        step_next = '0;
        if (warm[2])
        begin
            if (code_diff == 2'b11)
            begin
                // both lines flipped, direction unknown
                step_next.illegal = 1'b1;
            end
            else if (code_diff != 2'b00)
            begin
                step_next.step = 1'b1;
                // old a against new b gives 1 going forward
                step_next.dir  = code_prev[1] ^ sync_2[0];
            end
        end
    end

    // previous code and registered step output
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            code_prev <= 2'b00;
            warm      <= 3'b000;
            step_info <= '0;
        end
        else
        begin
            code_prev <= sync_2;
            warm      <= {warm[1:0], 1'b1};
            step_info <= step_next;
        end
    end

    // illegal replaces the step, never comes with it
    a_step_illegal_excl: assert property (
        @(posedge clk_fast) disable iff (reset)
        !(step_info.step && step_info.illegal)
    );

endmodule

// ==== verilog/enc_pkg.sv ====
// shared types for the quadrature encoder channel
// import with a wildcard in the module header
// widths come from the cfg header

`include "enc_cfg.svh"

package enc_pkg;

    // decoded transition from the quadrature decoder
    // step and illegal never appear together
    typedef struct packed {
        // one cycle pulse per legal gray transition
        logic step;
        // 1 for forward, 0 for backward
        logic dir;
        // both lines moved between two samples
        logic illegal;
    } enc_step_t;

    // measurement word published once per step
    typedef struct packed {
        // signed cycle count between steps
        // zero on overflow or reversal
        logic signed [`ENC_PERIOD_WIDTH-1:0] period;
        // count after this step
        logic signed [`ENC_POS_WIDTH-1:0]    position;
        // direction of this step
        logic                                dir;
        // gap reached the saturation limit
        logic                                overflow;
        // direction differs from the step before
        logic                                reversal;
    } enc_meas_t;

endpackage

// ==== verilog/enc_cfg.svh ====
// width and limit settings for the quadrature encoder channel
// included by the package and by the rtl blocks that size counters from it

`ifndef ENC_CFG_SVH
`define ENC_CFG_SVH

// signed period word width in bits
`define ENC_PERIOD_WIDTH 16

// elapsed cycle count where the period counter parks
// equals the most negative value of a signed 16 bit word
// so any positive measurement still fits in the period word
`define ENC_PERIOD_MAX 32768

// signed position count width in bits
// wraps around at either end
`define ENC_POS_WIDTH 24

`endif
